/* Bender.yml */
package:
  name: cpu85_core

sources:
  - rtl/cpu85_pkg.sv
  - rtl/cpu85_alu.sv
  - rtl/cpu85_regs.sv
  - rtl/cpu85_decode.sv
  - rtl/cpu85_timing.sv
  - rtl/cpu85_core.sv
  - target: test
    files:
      - bench/cpu85_chk.sv
      - bench/cpu85_monitor.sv
      - bench/tb_cpu85.sv

/* bench/cpu85_chk.sv */
`timescale 1ns/1ps

module cpu85_chk (
	input logic                         clk,
	input logic                         rst,
	input logic                         i_ready,
	input logic [cpu85_pkg::ADDR_W-1:0] i_addr,
	input logic                         i_ale,
	input logic                         i_rd_n,
	input logic                         i_wr_n
);
	int   fail_cnt = 0;
	logic strobe; // any bus strobe low

	assign strobe = !i_rd_n || !i_wr_n;

	ale_apart: assert property (@(posedge clk) disable iff (rst) !(i_ale && strobe))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("ALE high while a read or write strobe is low");
		end

	rd_wr_apart: assert property (@(posedge clk) disable iff (rst) !(!i_rd_n && !i_wr_n))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("read and write strobes low together");
		end

	// wait states freeze the bus
	hold_in_wait: assert property (@(posedge clk) disable iff (rst)
		strobe && $past(strobe) && $past(!i_ready)
		|-> $stable(i_addr) && $stable(i_rd_n) && $stable(i_wr_n))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("address or strobe moved during a wait state");
		end

endmodule

/* bench/cpu85_monitor.sv */
`timescale 1ns/1ps

module cpu85_monitor (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [cpu85_pkg::ADDR_W-1:0] i_addr,
	input  logic [cpu85_pkg::DATA_W-1:0] i_rdata,
	input  logic [cpu85_pkg::DATA_W-1:0] i_wdata,
	input  logic                         i_ale,
	input  logic                         i_rd_n,
	input  logic                         i_wr_n,
	input  logic [1:0]                   i_s,
	input  logic                         i_iom_n,
	output int                           o_errors,
	output int                           o_cycles,
	output logic                         o_halted
);
	import cpu85_pkg::*;

	typedef enum logic [1:0] {PH_FETCH, PH_IMM, PH_WRITE, PH_HALT} phase_e;

	logic [DATA_W-1:0] r [8]; // model registers with A in slot 7
	logic              cy;
	logic [ADDR_W-1:0] pc;
	logic [DATA_W-1:0] ir;    // opcode waiting for its immediate
	logic [DATA_W-1:0] exp_wdata;
	logic [DATA_W-1:0] rd_q;
	logic [DATA_W-1:0] wd_q;
	phase_e            phase;
	logic              in_cyc;
	logic              seen_low;
	logic              first;
	int                errors = 0;
	int                n_bus = 0;

	task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
		$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic alu_exec(input logic [2:0] op, input logic [DATA_W-1:0] b);
		logic [DATA_W:0] t;
		case (op)
			3'd0:       t = {1'b0, r[7]} + {1'b0, b};
			3'd1:       t = {1'b0, r[7]} + {1'b0, b} + {8'd0, cy};
			3'd2, 3'd7: t = {1'b0, r[7]} - {1'b0, b}; // top bit is the borrow
			3'd3:       t = {1'b0, r[7]} - {1'b0, b} - {8'd0, cy};
			3'd4:       t = {1'b0, r[7] & b};
			3'd5:       t = {1'b0, r[7] ^ b};
			default:    t = {1'b0, r[7] | b};
		endcase
		cy = t[DATA_W];
		if (op != 3'd7) begin
			r[7] = t[DATA_W-1:0]; // CMP leaves A alone
		end
	endtask

	task automatic exec_opcode(input logic [DATA_W-1:0] op);
		logic [2:0] d;
		logic [2:0] s;
		d     = op[5:3];
		s     = op[2:0];
		ir    = op;
		phase = PH_FETCH;
		case (op[7:6])
			2'b00: begin
				if (s == 3'd6 && d != 3'd6) begin
					phase = PH_IMM; // MVI r
				end
			end
			2'b01: begin
				if (d == 3'd6 && s == 3'd6) begin
					phase = PH_HALT;
				end else if (d == 3'd6) begin
					phase     = PH_WRITE;
					exp_wdata = r[s];
				end else if (s != 3'd6) begin
					r[d] = r[s];
				end
			end
			2'b10: begin
				if (s != 3'd6) begin
					alu_exec(d, r[s]);
				end
			end
			default: begin
				if (s == 3'd6) begin
					phase = PH_IMM; // ALU immediate
				end
			end
		endcase
	endtask

	task automatic start_cycle();
		logic [1:0]        exp_s;
		logic [ADDR_W-1:0] exp_addr;
		exp_addr = pc;
		case (phase)
			PH_FETCH: exp_s = 2'b11;
			PH_IMM:   exp_s = 2'b10;
			PH_WRITE: begin
				exp_s    = 2'b01;
				exp_addr = {r[4], r[5]}; // HL
			end
			default: begin
				$display("error at t=%0t: a bus cycle started after HLT", $time);
				errors++;
				return;
			end
		endcase
		if (i_s !== exp_s) begin
			mismatch("o_s", i_s, exp_s);
		end
		if (i_addr !== exp_addr) begin
			mismatch("o_addr", i_addr, exp_addr);
		end
		if (i_iom_n !== 1'b0) begin
			mismatch("o_iom_n", i_iom_n, 1'b0);
		end
		in_cyc   = 1'b1;
		seen_low = 1'b0;
	endtask

	task automatic finish_cycle();
		in_cyc   = 1'b0;
		seen_low = 1'b0;
		n_bus++;
		case (phase)
			PH_FETCH: begin
				pc++;
				exec_opcode(rd_q);
			end
			PH_IMM: begin
				pc++;
				phase = PH_FETCH;
				if (ir[7:6] == 2'b00) begin
					r[ir[5:3]] = rd_q;
				end else begin
					alu_exec(ir[5:3], rd_q);
				end
			end
			PH_WRITE: begin
				phase = PH_FETCH;
				if (wd_q !== exp_wdata) begin
					mismatch("o_wdata", wd_q, exp_wdata);
				end
			end
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------
	// one pass per clock on the values before the edge
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				r[i] = '0;
			end
			cy       = 1'b0;
			pc       = RESET_PC;
			phase    = PH_FETCH;
			in_cyc   = 1'b0;
			seen_low = 1'b0;
			first    = 1'b1;
			if (!i_rd_n || !i_wr_n || i_ale) begin
				$display("error at t=%0t: bus strobe active during reset", $time);
				errors++;
			end
		end else begin
			if (first && (!i_rd_n || !i_wr_n || i_ale)) begin
				$display("error at t=%0t: bus strobe active right after reset", $time);
				errors++;
			end
			first = 1'b0;
			if (phase == PH_HALT && !in_cyc) begin
				if (i_s !== 2'b00) begin
					mismatch("o_s", i_s, 2'b00);
				end
				if (i_iom_n !== 1'b1) begin
					mismatch("o_iom_n", i_iom_n, 1'b1);
				end
				if (!i_rd_n || !i_wr_n) begin
					$display("error at t=%0t: bus strobe active while halted", $time);
					errors++;
				end
			end
			if (in_cyc) begin
				if (!i_rd_n) begin
					rd_q = i_rdata;
				end
				if (!i_wr_n) begin
					wd_q = i_wdata;
				end
				if (!i_rd_n || !i_wr_n) begin
					seen_low = 1'b1;
				end else if (seen_low) begin
					finish_cycle(); // strobe went back high
				end
			end
			if (i_ale) begin
				start_cycle();
			end
		end
	end

	assign o_errors = errors;
	assign o_cycles = n_bus;
	assign o_halted = (phase == PH_HALT);

endmodule

/* bench/tb_cpu85.sv */
`timescale 1ns/1ps

module tb_cpu85;
	import cpu85_pkg::*;

	localparam int N_INSTR    = 150;
	localparam int MAX_WAITS  = 8;
	localparam int MAX_CYCLES = N_INSTR * (7 + 3 * MAX_WAITS) + 100;

	logic              clk;
	logic              rst;
	logic              ready;
	logic [DATA_W-1:0] rdata;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              ale;
	logic              rd_n;
	logic              wr_n;
	logic              iom_n;
	logic [1:0]        s;

	logic [DATA_W-1:0] mem [0:65535];
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	integer            seed;
	int                wp;       // program write pointer
	int                cycles;
	int                wait_run; // waits in a row
	int                mon_errors;
	int                mon_cycles;
	logic              halted;

	cpu85_core dut0 (
		.clk    (clk),
		.rst    (rst),
		.i_ready(ready),
		.i_rdata(rdata),
		.o_addr (addr),
		.o_wdata(wdata),
		.o_ale  (ale),
		.o_rd_n (rd_n),
		.o_wr_n (wr_n),
		.o_iom_n(iom_n),
		.o_s    (s)
	);

	cpu85_monitor mon0 (
		.clk     (clk),
		.rst     (rst),
		.i_addr  (addr),
		.i_rdata (rdata),
		.i_wdata (wdata),
		.i_ale   (ale),
		.i_rd_n  (rd_n),
		.i_wr_n  (wr_n),
		.i_s     (s),
		.i_iom_n (iom_n),
		.o_errors(mon_errors),
		.o_cycles(mon_cycles),
		.o_halted(halted)
	);

	bind cpu85_core cpu85_chk chk0 (
		.clk    (clk),
		.rst    (rst),
		.i_ready(i_ready),
		.i_addr (o_addr),
		.i_ale  (o_ale),
		.i_rd_n (o_rd_n),
		.i_wr_n (o_wr_n)
	);

	always #5 clk = ~clk;

	function automatic int rnd(input int n);
		rnd = $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [2:0] pick_dst();
		logic [2:0] v;
		v        = 3'(rnd(5));
		pick_dst = (v == 3'd4) ? 3'd7 : v; // B C D E or A so HL stays put
	endfunction

	function automatic logic [2:0] pick_src();
		logic [2:0] v;
		v        = 3'(rnd(7));
		pick_src = (v == 3'd6) ? 3'd7 : v; // never M
	endfunction

	task automatic emit(input logic [DATA_W-1:0] b);
		mem[wp] = b;
		wp++;
	endtask

	// ------------------------------------------------------------
	// random program at address 0 with HL above 8000h
	// ------------------------------------------------------------
	task automatic build_program();
		int         kind;
		logic [2:0] d;
		logic [2:0] sr;
		for (int a = 0; a < 65536; a++) begin
			mem[a] = 8'(a[15:8] ^ a[7:0]);
		end
		wp = 0;
		emit(8'h26); // MVI H
		emit(8'h80 | 8'(rnd(128)));
		emit(8'h2E); // MVI L
		emit(8'(rnd(256)));
		for (int i = 0; i < N_INSTR - 3; i++) begin
			kind = rnd(8);
			d    = pick_dst();
			sr   = pick_src();
			case (kind)
				0: emit(8'h00);
				1: emit({2'b01, d, sr});
				2: begin
					emit({2'b00, d, 3'b110});
					emit(8'(rnd(256)));
				end
				3: emit({5'b01110, sr});
				4: emit(8'h77); // MOV M,A shows the ALU results
				5, 6: emit({2'b10, 3'(rnd(8)), sr});
				default: begin
					emit({2'b11, 3'(rnd(8)), 3'b110});
					emit(8'(rnd(256)));
				end
			endcase
		end
		emit(8'h76); // HLT
	endtask

	task automatic print_counts();
		$display("errors: monitor %0d, assertions %0d; bus cycles %0d, clock cycles %0d",
			mon_errors, dut0.chk0.fail_cnt, mon_cycles, cycles);
	endtask

	assign rdata = mem[addr];

	always @(posedge clk) begin
		if (!wr_n) begin
			wr_addr = addr;
			wr_data = wdata;
		end
	end

	always @(posedge wr_n) begin
		if (!rst) begin
			mem[wr_addr] = wr_data;
		end
	end

	always @(posedge clk) begin
		#1;
		if (wait_run >= MAX_WAITS || rnd(4) != 0) begin
			ready    = 1'b1;
			wait_run = 0;
		end else begin
			ready    = 1'b0;
			wait_run = wait_run + 1;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: HLT not reached within %0d cycles", MAX_CYCLES);
			print_counts();
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		ready    = 1'b1;
		seed     = 26757;
		cycles   = 0;
		wait_run = 0;
		build_program();
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;
		wait (halted);
		repeat (40) @(posedge clk); // bus must stay quiet after HLT
		print_counts();
		if (mon_errors == 0 && dut0.chk0.fail_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* cpu85_core.f */
rtl/cpu85_pkg.sv
rtl/cpu85_alu.sv
rtl/cpu85_regs.sv
rtl/cpu85_decode.sv
rtl/cpu85_timing.sv
rtl/cpu85_core.sv
bench/cpu85_chk.sv
bench/cpu85_monitor.sv
bench/tb_cpu85.sv

/* rtl/cpu85_alu.sv */
`timescale 1ns/1ps

module cpu85_alu (
	input  cpu85_pkg::alu_op_e           i_op,
	input  logic [cpu85_pkg::DATA_W-1:0] i_a,
	input  logic [cpu85_pkg::DATA_W-1:0] i_b,
	input  logic                         i_cy,
	output logic [cpu85_pkg::DATA_W-1:0] o_res,
	output logic [cpu85_pkg::DATA_W-1:0] o_flags
);
	import cpu85_pkg::*;

	logic              is_sub;
	logic              cin;
	logic [DATA_W-1:0] b_eff;
	logic [DATA_W:0]   sum;
	logic [4:0]        nib; // low nibble sum for AC
	logic [DATA_W-1:0] res;
	logic              cy;
	logic              ac;
	logic [DATA_W-1:0] flags;

	// ------------------------------------------------------------
	// shared adder, subtract is a + ~b + 1
	// ------------------------------------------------------------
	always_comb begin
		is_sub = (i_op == ALU_SUB) || (i_op == ALU_SBB) || (i_op == ALU_CMP);
		b_eff  = is_sub ? ~i_b : i_b;
		case (i_op)
			ALU_ADC:          cin = i_cy;
			ALU_SUB, ALU_CMP: cin = 1'b1;
			ALU_SBB:          cin = ~i_cy; // borrow in
			default:          cin = 1'b0;
		endcase
		sum = {1'b0, i_a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, cin};
		nib = {1'b0, i_a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};
	end

	always_comb begin
		case (i_op)
			ALU_ANA: begin
				res = i_a & i_b;
				cy  = 1'b0;
				ac  = i_a[3] | i_b[3];
			end
			ALU_XRA: begin
				res = i_a ^ i_b;
				cy  = 1'b0;
				ac  = 1'b0;
			end
			ALU_ORA: begin
				res = i_a | i_b;
				cy  = 1'b0;
				ac  = 1'b0;
			end
			default: begin
				res = sum[DATA_W-1:0];
				cy  = sum[DATA_W] ^ is_sub; // borrow for subtract
				ac  = nib[4];
			end
		endcase
	end

	always_comb begin
		flags          = '0;
		flags[FLAG_S]  = res[DATA_W-1];
		flags[FLAG_Z]  = (res == '0);
		flags[FLAG_AC] = ac;
		flags[FLAG_P]  = ~^res; // even parity
		flags[FLAG_CY] = cy;
	end

	assign o_res   = res;
	assign o_flags = flags & FLAG_MASK;

endmodule

/* rtl/cpu85_core.sv */
`timescale 1ns/1ps

module cpu85_core (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_ready,
	input  logic [cpu85_pkg::DATA_W-1:0] i_rdata,
	output logic [cpu85_pkg::ADDR_W-1:0] o_addr,
	output logic [cpu85_pkg::DATA_W-1:0] o_wdata,
	output logic                         o_ale,
	output logic                         o_rd_n,
	output logic                         o_wr_n,
	output logic                         o_iom_n,
	output logic [1:0]                   o_s
);
	import cpu85_pkg::*;

	decoded_t          dec;
	commit_t           commit;
	logic              ir_load;
	logic [ADDR_W-1:0] hl;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] opa;
	logic [DATA_W-1:0] opb;
	logic              cy;
	logic [DATA_W-1:0] alu_res;
	logic [DATA_W-1:0] alu_flags;

	cpu85_timing timing0 (
		.clk      (clk),
		.rst      (rst),
		.i_ready  (i_ready),
		.i_rdata  (i_rdata),
		.i_dec    (dec),
		.i_hl     (hl),
		.i_wdata  (wdata),
		.o_ir_load(ir_load),
		.o_commit (commit),
		.o_addr   (o_addr),
		.o_wdata  (o_wdata),
		.o_ale    (o_ale),
		.o_rd_n   (o_rd_n),
		.o_wr_n   (o_wr_n),
		.o_iom_n  (o_iom_n),
		.o_s      (o_s)
	);

	cpu85_decode decode0 (
		.clk     (clk),
		.rst     (rst),
		.i_load  (ir_load),
		.i_opcode(i_rdata), // fetched byte
		.o_dec   (dec)
	);

	cpu85_regs regs0 (
		.clk        (clk),
		.rst        (rst),
		.i_dec      (dec),
		.i_commit   (commit),
		.i_alu_res  (alu_res),
		.i_alu_flags(alu_flags),
		.o_opa      (opa),
		.o_opb      (opb),
		.o_cy       (cy),
		.o_hl       (hl),
		.o_wdata    (wdata)
	);

	cpu85_alu alu0 (
		.i_op   (dec.op),
		.i_a    (opa),
		.i_b    (opb),
		.i_cy   (cy),
		.o_res  (alu_res),
		.o_flags(alu_flags)
	);

endmodule

/* rtl/cpu85_decode.sv */
`timescale 1ns/1ps

module cpu85_decode (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_load,
	input  logic [cpu85_pkg::DATA_W-1:0] i_opcode,
	output cpu85_pkg::decoded_t          o_dec
);
	import cpu85_pkg::*;

	logic [DATA_W-1:0] ir;
	logic [1:0]        grp; // top two bits
	reg_idx_e          mid; // bits 5:3
	reg_idx_e          lo;  // bits 2:0
	instr_cls_e        cls;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ir <= OPC_NOP;
		end else if (i_load) begin
			ir <= i_opcode;
		end
	end

	assign grp = ir[7:6];
	assign mid = reg_idx_e'(ir[5:3]);
	assign lo  = reg_idx_e'(ir[2:0]);

	always_comb begin
		cls = CLS_NOP;
		case (grp)
			2'b00: begin // only MVI r is kept here
				if (lo == REG_M && mid != REG_M) begin
					cls = CLS_MVI_R;
				end
			end
			2'b01: begin
				if (mid == REG_M && lo == REG_M) begin
					cls = CLS_HLT;
				end else if (mid == REG_M) begin
					cls = CLS_MOV_MR;
				end else if (lo != REG_M) begin
					cls = CLS_MOV_RR;
				end
			end
			2'b10: begin
				if (lo != REG_M) begin
					cls = CLS_ALU_R;
				end
			end
			default: begin
				if (lo == REG_M) begin
					cls = CLS_ALU_I; // 11ooo110
				end
			end
		endcase
	end

	assign o_dec.cls = cls;
	assign o_dec.dst = mid;
	assign o_dec.src = lo;
	assign o_dec.op  = alu_op_e'(ir[5:3]);

endmodule

/* rtl/cpu85_pkg.sv */
package cpu85_pkg;

	// ------------------------------------------------------------
	// widths and constants
	// ------------------------------------------------------------
	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	localparam logic [DATA_W-1:0] FLAG_MASK = 8'b1101_0101; // S Z - AC - P - CY
	localparam int FLAG_S  = 7;
	localparam int FLAG_Z  = 6;
	localparam int FLAG_AC = 4;
	localparam int FLAG_P  = 2;
	localparam int FLAG_CY = 0;

	localparam logic [ADDR_W-1:0] RESET_PC = 16'h0000;
	localparam logic [DATA_W-1:0] OPC_NOP  = 8'h00;

	// ------------------------------------------------------------
	// enums
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		REG_B = 3'd0,
		REG_C = 3'd1,
		REG_D = 3'd2,
		REG_E = 3'd3,
		REG_H = 3'd4,
		REG_L = 3'd5,
		REG_M = 3'd6, // memory operand
		REG_A = 3'd7
	} reg_idx_e;

	typedef enum logic [2:0] {
		ST_TR, ST_T1, ST_T2, ST_TW, ST_T3, ST_T4, ST_TT
	} tstate_e;

	// value is the S1,S0 status code
	typedef enum logic [1:0] {
		CYC_OF  = 2'b11, // opcode fetch
		CYC_MR  = 2'b10, // memory read
		CYC_MW  = 2'b01, // memory write
		CYC_BIH = 2'b00  // halted or in reset
	} mcycle_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP
	} alu_op_e;

	typedef enum logic [2:0] {
		CLS_NOP, CLS_MOV_RR, CLS_MVI_R, CLS_MOV_MR, CLS_ALU_R, CLS_ALU_I, CLS_HLT
	} instr_cls_e;

	// ------------------------------------------------------------
	// structs
	// ------------------------------------------------------------
	typedef struct packed {
		instr_cls_e cls;
		reg_idx_e   dst;
		reg_idx_e   src;
		alu_op_e    op;
	} decoded_t;

	typedef struct packed {
		logic              stb;   // write registers on this edge
		logic [DATA_W-1:0] rdata; // byte from the bus
	} commit_t;

endpackage

/* rtl/cpu85_regs.sv */
`timescale 1ns/1ps

module cpu85_regs (
	input  logic                         clk,
	input  logic                         rst,
	input  cpu85_pkg::decoded_t          i_dec,
	input  cpu85_pkg::commit_t           i_commit,
	input  logic [cpu85_pkg::DATA_W-1:0] i_alu_res,
	input  logic [cpu85_pkg::DATA_W-1:0] i_alu_flags,
	output logic [cpu85_pkg::DATA_W-1:0] o_opa,
	output logic [cpu85_pkg::DATA_W-1:0] o_opb,
	output logic                         o_cy,
	output logic [cpu85_pkg::ADDR_W-1:0] o_hl,
	output logic [cpu85_pkg::DATA_W-1:0] o_wdata
);
	import cpu85_pkg::*;

	// slot M holds the flag register
	logic [DATA_W-1:0] rf [8];
	logic [DATA_W-1:0] flags;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				rf[i] <= '0;
			end
		end else if (i_commit.stb) begin
			case (i_dec.cls)
				CLS_MOV_RR: rf[i_dec.dst] <= rf[i_dec.src];
				CLS_MVI_R:  rf[i_dec.dst] <= i_commit.rdata;
				CLS_ALU_R, CLS_ALU_I: begin
					if (i_dec.op != ALU_CMP) begin
						rf[REG_A] <= i_alu_res; // compare keeps A
					end
					rf[REG_M] <= i_alu_flags;
				end
				default: ; // NOP writes nothing
			endcase
		end
	end

	assign flags = rf[REG_M];

	assign o_opa   = rf[REG_A];
	assign o_opb   = (i_dec.cls == CLS_ALU_I) ? i_commit.rdata : rf[i_dec.src];
	assign o_cy    = flags[FLAG_CY];
	assign o_hl    = {rf[REG_H], rf[REG_L]};
	assign o_wdata = rf[i_dec.src]; // MOV M,r source

endmodule

/* rtl/cpu85_timing.sv */
`timescale 1ns/1ps

module cpu85_timing (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_ready,
	input  logic [cpu85_pkg::DATA_W-1:0] i_rdata,
	input  cpu85_pkg::decoded_t          i_dec,
	input  logic [cpu85_pkg::ADDR_W-1:0] i_hl,
	input  logic [cpu85_pkg::DATA_W-1:0] i_wdata,
	output logic                         o_ir_load,
	output cpu85_pkg::commit_t           o_commit,
	output logic [cpu85_pkg::ADDR_W-1:0] o_addr,
	output logic [cpu85_pkg::DATA_W-1:0] o_wdata,
	output logic                         o_ale,
	output logic                         o_rd_n,
	output logic                         o_wr_n,
	output logic                         o_iom_n,
	output logic [1:0]                   o_s
);
	import cpu85_pkg::*;

	tstate_e           state, state_d;
	mcycle_e           cyc, cyc_d;
	logic [ADDR_W-1:0] pc, pc_d;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic              bus_act;

	// ------------------------------------------------------------
	// next T-state and machine cycle
	// ------------------------------------------------------------
	always_comb begin
		state_d = state;
		cyc_d   = cyc;
		case (state)
			ST_TR: begin
				state_d = ST_T1;
				cyc_d   = CYC_OF;
			end
			ST_T1: state_d = ST_T2;
			ST_T2, ST_TW: state_d = i_ready ? ST_T3 : ST_TW; // stretch while not ready
			ST_T3: begin
				if (cyc == CYC_OF) begin
					state_d = ST_T4;
				end else begin
					state_d = ST_T1;
					cyc_d   = CYC_OF;
				end
			end
			ST_T4: begin
				state_d = ST_T1;
				case (i_dec.cls)
					CLS_HLT: begin
						state_d = ST_TT;
						cyc_d   = CYC_BIH;
					end
					CLS_MVI_R, CLS_ALU_I: cyc_d = CYC_MR; // immediate byte
					CLS_MOV_MR:           cyc_d = CYC_MW;
					default:              cyc_d = CYC_OF;
				endcase
			end
			default: state_d = ST_TT; // halted until reset
		endcase
	end

	// pc steps past every byte read from the program
	assign pc_d = (state == ST_T3 && cyc != CYC_MW) ? pc + 16'd1 : pc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state  <= ST_TR;
			cyc    <= CYC_BIH;
			pc     <= RESET_PC;
			addr_q <= RESET_PC;
		end else begin
			state <= state_d;
			cyc   <= cyc_d;
			pc    <= pc_d;
			if (state_d == ST_T1) begin
				addr_q <= (cyc_d == CYC_MW) ? i_hl : pc_d; // held for the whole cycle
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_d == ST_T1 && cyc_d == CYC_MW) begin
			wdata_q <= i_wdata;
		end
	end

	// ------------------------------------------------------------
	// pins and internal strobes
	// ------------------------------------------------------------
	assign bus_act = (state == ST_T2) || (state == ST_TW) || (state == ST_T3);

	assign o_addr  = addr_q;
	assign o_wdata = wdata_q;
	assign o_ale   = (state == ST_T1);
	assign o_rd_n  = ~(bus_act && (cyc == CYC_OF || cyc == CYC_MR));
	assign o_wr_n  = ~(bus_act && cyc == CYC_MW);
	assign o_iom_n = (cyc == CYC_BIH); // no bus cycle running
	assign o_s     = cyc;

	assign o_ir_load = (state == ST_T3) && (cyc == CYC_OF);

	assign o_commit.stb = ((state == ST_T3) && (cyc == CYC_MR)) ||
		((state == ST_T4) &&
		(i_dec.cls == CLS_NOP || i_dec.cls == CLS_MOV_RR || i_dec.cls == CLS_ALU_R));
	assign o_commit.rdata = i_rdata;

endmodule
